/* project.f */
hdl/core_pkg.sv
hdl/regfile_if.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/alu.sv
hdl/execute_unit.sv
hdl/core_top.sv
bench/tb_clock_gen.sv
bench/tb_core.sv

/* bench/tb_core.sv */
`timescale 1ns/1ps

module tb_core;

	localparam int          SEED       = 85;
	localparam logic [31:0] RESET_VEC  = 32'h0;
	localparam logic [31:0] NOP_WORD   = 32'h0000_0013;
	localparam int          N_LOADS    = 8;  // lui + addi pairs
	localparam int          N_RANDOM   = 40;
	localparam int          N_STORES   = 32; // one per register
	localparam int          PROG_LEN   = 2 * N_LOADS + N_RANDOM + N_STORES;
	localparam int          MAX_CYCLES = 2 + PROG_LEN + 20;
	localparam int          IMEM_WORDS = 128;
	localparam logic [11:0] STORE_BASE = 12'h100;

	localparam logic [6:0] OPC_LUI   = 7'b0110111;
	localparam logic [6:0] OPC_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP    = 7'b0110011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data; // zero outside the enabled lanes
		logic [3:0]  mask;
	} store_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] instr;
	logic [31:0] instr_addr;
	logic [31:0] data_addr;
	logic [31:0] data_wdata;
	logic [3:0]  data_wmask;
	logic        data_wen;
	logic        data_req;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] arch_regs [32];
	store_t      exp_q [$];
	logic [31:0] fetch_addr;
	logic [31:0] exp_fetch;
	int          n_errors;
	int          n_strobes;
	int          cycle_cnt;

	tb_clock_gen u_clk_gen (
		.clk_o   (clk),
		.reset_o (rst_n)
	);

	core_top #(
		.RESET_VECTOR (RESET_VEC)
	) dut_i (
		.clk_i        (clk),
		.reset_i      (rst_n),
		.instr_i      (instr),
		.instr_addr_o (instr_addr),
		.data_addr_o  (data_addr),
		.data_o       (data_wdata),
		.data_wmask_o (data_wmask),
		.data_wen_o   (data_wen),
		.data_req_o   (data_req)
	);

	// rv32i integer result by funct3 with alt selecting sub or sra
	function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5:
			begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic void ref_execute(input logic [31:0] instr_word);
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] res;
		logic        we;
		store_t      st;
		rd    = instr_word[11:7];
		f3    = instr_word[14:12];
		f7    = instr_word[31:25];
		a     = arch_regs[instr_word[19:15]];
		b     = arch_regs[instr_word[24:20]];
		imm_i = {{20{instr_word[31]}}, instr_word[31:20]};
		imm_s = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};
		we    = 1'b0;
		res   = '0;
		case (instr_word[6:0])
			OPC_LUI:
			begin
				res = {instr_word[31:12], 12'b0};
				we  = 1'b1;
			end
			OPC_IMM:
			begin
				res = isa_alu(f3, f3 == 3'd5 && instr_word[30], a, imm_i);
				// shift immediates carry their own funct7
				we  = (f3 == 3'd1) ? f7 == 7'h00 :
					(f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
			end
			OPC_OP:
			begin
				res = isa_alu(f3, instr_word[30], a, b);
				we  = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			end
			OPC_STORE:
			begin
				if (f3 <= 3'd2)
				begin
					st.addr = a + imm_s;
					st.mask = (f3 == 3'd0) ? 4'b0001 << st.addr[1:0] :
						(f3 == 3'd1) ? 4'b0011 << st.addr[1:0] : 4'b1111;
					st.data = (f3 == 3'd0) ? {24'b0, b[7:0]} << {st.addr[1:0], 3'b0} :
						(f3 == 3'd1) ? {16'b0, b[15:0]} << {st.addr[1:0], 3'b0} : b;
					exp_q.push_back(st);
				end
			end
			default: ; // loads, branches and system ops have no effect
		endcase
		if (we && rd != 5'd0)
			arch_regs[rd] = res;
	endfunction

	task automatic build_program();
		logic [6:0]  bad_opc [4] = '{7'b0000011, 7'b1100011, 7'b1101111, 7'b1110011};
		logic [31:0] rnd;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  prev_rd;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		int          pc;
		pc      = 0;
		prev_rd = 5'd1;
		for (int r = 1; r <= N_LOADS; r++)
		begin
			rnd          = $urandom();
			imem[pc]     = {rnd[31:12], 5'(r), OPC_LUI};
			imem[pc + 1] = {rnd[11:0], 5'(r), 3'd0, 5'(r), OPC_IMM}; // addi right on the lui
			pc += 2;
		end
		for (int n = 0; n < N_RANDOM; n++)
		begin
			rnd = $urandom();
			rd  = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom_range(1, 15));
			rs1 = ($urandom_range(0, 2) == 0) ? prev_rd : 5'($urandom_range(0, 15));
			rs2 = ($urandom_range(0, 2) == 0) ? prev_rd : 5'($urandom_range(0, 15));
			f3  = rnd[14:12];
			if ($urandom_range(0, 9) == 0)
				imem[pc] = {rnd[31:7], bad_opc[rnd[3:2]]};
			else if (rnd[0])
			begin
				f7       = ((f3 == 3'd0 || f3 == 3'd5) && rnd[1]) ? 7'h20 : 7'h00;
				imem[pc] = {f7, rs2, rs1, f3, rd, OPC_OP};
			end
			else
			begin
				imm = rnd[31:20];
				if (f3 == 3'd1 || f3 == 3'd5)
					imm = {(f3 == 3'd5 && rnd[1]) ? 7'h20 : 7'h00, rs2}; // shamt
				imem[pc] = {imm, rs1, f3, rd, OPC_IMM};
			end
			prev_rd = rd;
			pc++;
		end
		// sb sh sw in turn off x0 and 8 bytes apart
		for (int r = 0; r < N_STORES; r++)
		begin
			f3  = 3'(r % 3);
			imm = STORE_BASE + 12'(r * 8);
			if (f3 == 3'd0)
				imm += 12'($urandom_range(0, 3));
			else if (f3 == 3'd1)
				imm += 12'(2 * $urandom_range(0, 1));
			imem[pc] = {imm[11:5], 5'(r), 5'd0, f3, imm[4:0], OPC_STORE};
			pc++;
		end
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		n_errors++;
		$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
	endtask

	task automatic check_outputs();
		store_t      st;
		logic [31:0] lanes;
		if (rst_n !== 1'b1)
		begin
			exp_fetch = RESET_VEC;
			if (instr_addr !== exp_fetch)
				report_mismatch("fetch address in reset", instr_addr, exp_fetch);
		end
		else
		begin
			exp_fetch += 32'd4;
			if (instr_addr !== exp_fetch)
				report_mismatch("fetch address step", instr_addr, exp_fetch);
		end
		if (data_req !== 1'b1)
		begin
			if (data_req !== 1'b0 || data_wen !== 1'b1)
				report_mismatch("idle {req, wen}", {30'b0, data_req, data_wen}, 32'h1);
		end
		else if (exp_q.size() == 0)
		begin
			n_strobes++;
			n_errors++;
			$display("store strobe at %0t with no store left in the program", $time);
		end
		else
		begin
			n_strobes++;
			st    = exp_q.pop_front();
			lanes = {{8{st.mask[3]}}, {8{st.mask[2]}}, {8{st.mask[1]}}, {8{st.mask[0]}}};
			if (data_wen !== 1'b0)
				report_mismatch("write enable during store", {31'b0, data_wen}, 32'h0);
			if (data_addr !== st.addr)
				report_mismatch("store address", data_addr, st.addr);
			if (data_wmask !== st.mask)
				report_mismatch("store mask", {28'b0, data_wmask}, {28'b0, st.mask});
			if ((data_wdata & lanes) !== st.data)
				report_mismatch("store data in enabled lanes", data_wdata & lanes, st.data);
		end
	endtask

	// synchronous instruction memory with the address taken mid-cycle
	always @(negedge clk)
		fetch_addr = instr_addr;

	always @(posedge clk)
	begin
		#1;
		instr = imem[7'((fetch_addr - RESET_VEC) >> 2)];
	end

	// outputs sampled mid-cycle once the first rising edge has passed
	always @(negedge clk)
		if (cycle_cnt > 0)
			check_outputs();

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("timeout after %0d cycles, %0d of %0d stores seen, errors: %0d",
				cycle_cnt, n_strobes, N_STORES, n_errors);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(SEED));
		instr      = NOP_WORD;
		fetch_addr = RESET_VEC;
		exp_fetch  = RESET_VEC;
		n_errors   = 0;
		n_strobes  = 0;
		cycle_cnt  = 0;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = {i[24:0], 7'b0000011}; // load opcode executes as a nop
		for (int i = 0; i < 32; i++)
			arch_regs[i] = '0;
		build_program();
		for (int i = 0; i < PROG_LEN; i++)
			ref_execute(imem[i]);
		wait (rst_n === 1'b1);
		while (n_strobes < N_STORES)
			@(posedge clk);
		repeat (5) @(posedge clk); // a stray strobe would show up here
		if (n_strobes != N_STORES)
		begin
			n_errors++;
			$display("saw %0d store strobes, program has %0d stores", n_strobes, N_STORES);
		end
		$display("errors: %0d, store strobes: %0d of %0d", n_errors, n_strobes, N_STORES);
		if (n_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_o,
	output logic reset_o
);

	initial
	begin
		clk_o   = 1'b0;
		reset_o = 1'b0; // active low, asserted from time zero
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1 reset_o = 1'b1;
	end

	always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* hdl/core_top.sv */
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
	parameter word_t RESET_VECTOR = 32'h0
) (
	input  logic       clk_i,
	input  logic       reset_i,     // active low
	input  word_t      instr_i,
	output word_t      instr_addr_o,
	output word_t      data_addr_o,
	output word_t      data_o,
	output logic [3:0] data_wmask_o,
	output logic       data_wen_o,  // low during a store
	output logic       data_req_o
);

	word_t  if_instr;
	id_ex_t id_ex;

	regfile_if rf_bus ();

	fetch_unit #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_fetch (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.instr_i      (instr_i),
		.instr_addr_o (instr_addr_o),
		.if_pc_o      (),
		.if_instr_o   (if_instr)
	);

	decode_unit u_decode (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.if_instr_i (if_instr),
		.rf         (rf_bus.reader),
		.id_ex_o    (id_ex)
	);

	register_file u_regfile (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.rf      (rf_bus.bank)
	);

	execute_unit u_execute (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.id_ex_i      (id_ex),
		.rf           (rf_bus.writer),
		.data_addr_o  (data_addr_o),
		.data_o       (data_o),
		.data_wmask_o (data_wmask_o),
		.data_wen_o   (data_wen_o),
		.data_req_o   (data_req_o)
	);

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit import core_pkg::*; (
	input  logic       clk_i,
	input  logic       reset_i,
	input  id_ex_t     id_ex_i,
	regfile_if.writer  rf,
	output word_t      data_addr_o,
	output word_t      data_o,
	output logic [3:0] data_wmask_o,
	output logic       data_wen_o,
	output logic       data_req_o
);

	logic  fwd_rs1;
	logic  fwd_rs2;
	word_t rs1_val;
	word_t rs2_val;
	word_t op_b;
	word_t alu_result;

	// writeback stage result bypasses the register file
	assign fwd_rs1 = rf.wb_we && (rf.wb_addr != '0) && (rf.wb_addr == id_ex_i.rs1);
	assign fwd_rs2 = rf.wb_we && (rf.wb_addr != '0) && (rf.wb_addr == id_ex_i.rs2);

	assign rs1_val = fwd_rs1 ? rf.wb_data : id_ex_i.rs1_data;
	assign rs2_val = fwd_rs2 ? rf.wb_data : id_ex_i.rs2_data;
	assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

	alu u_alu (
		.op_a_i   (rs1_val),
		.op_b_i   (op_b),
		.alu_op_i (id_ex_i.alu_op),
		.result_o (alu_result)
	);

	assign data_addr_o = alu_result;
	assign data_req_o  = id_ex_i.store;
	assign data_wen_o  = !id_ex_i.store; // active low

	always_comb
	begin
		case (id_ex_i.mem_len)
			BYTE:
			begin
				data_o       = {4{rs2_val[7:0]}};
				data_wmask_o = 4'b0001 << alu_result[1:0];
			end
			HALF:
			begin
				data_o       = {2{rs2_val[15:0]}};
				data_wmask_o = alu_result[1] ? 4'b1100 : 4'b0011;
			end
			default:
			begin
				data_o       = rs2_val;
				data_wmask_o = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			rf.wb_we   <= 1'b0;
			rf.wb_addr <= '0;
		end
		else
		begin
			rf.wb_we   <= id_ex_i.rf_we;
			rf.wb_addr <= id_ex_i.rd;
		end
	end

	always_ff @(posedge clk_i)
		rf.wb_data <= alu_result;

	// a store never reaches the register file one stage later
	a_store_strobe: assert property (@(posedge clk_i) disable iff (!reset_i)
		data_req_o |-> !data_wen_o ##1 !rf.wb_we);

	a_store_aligned: assert property (@(posedge clk_i) disable iff (!reset_i)
		data_req_o |-> (id_ex_i.mem_len == BYTE) ||
			(id_ex_i.mem_len == HALF && !data_addr_o[0]) ||
			(data_addr_o[1:0] == 2'b00));

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu import core_pkg::*; (
	input  word_t   op_a_i,
	input  word_t   op_b_i,
	input  alu_op_t alu_op_i,
	output word_t   result_o
);

	logic [4:0] shamt;

	assign shamt = op_b_i[4:0]; // upper bits ignored, also for srai

	always_comb
	begin
		case (alu_op_i)
			ADD:    result_o = op_a_i + op_b_i;
			SUB:    result_o = op_a_i - op_b_i;
			SLL:    result_o = op_a_i << shamt;
			SLT:    result_o = {{(XLEN-1){1'b0}}, ($signed(op_a_i) < $signed(op_b_i))};
			SLTU:   result_o = {{(XLEN-1){1'b0}}, (op_a_i < op_b_i)};
			XOR:    result_o = op_a_i ^ op_b_i;
			SRL:    result_o = op_a_i >> shamt;
			SRA:    result_o = $signed(op_a_i) >>> shamt;
			OR:     result_o = op_a_i | op_b_i;
			AND:    result_o = op_a_i & op_b_i;
			PASS_B: result_o = op_b_i;
			default: result_o = '0;
		endcase
	end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file import core_pkg::*; (
	input  logic    clk_i,
	input  logic    reset_i,
	regfile_if.bank rf
);

	word_t regs [NUM_REGS];

	// written mid-cycle so decode reads the new value before the next rising edge
	always_ff @(negedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (rf.wb_we && rf.wb_addr != '0)
			regs[rf.wb_addr] <= rf.wb_data;
	end

	// x0 reads as zero
	assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
	assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

endmodule

/* hdl/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit import core_pkg::*; (
	input  logic      clk_i,
	input  logic      reset_i,
	input  word_t     if_instr_i,
	regfile_if.reader rf,
	output id_ex_t    id_ex_o
);

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_u;
	logic       op_f7_ok; // legal funct7 for reg-reg ops
	id_ex_t     dec;

	assign opcode = opcode_t'(if_instr_i[6:0]);
	assign funct3 = if_instr_i[14:12];
	assign funct7 = if_instr_i[31:25];

	assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
	assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
	assign imm_u = {if_instr_i[31:12], 12'b0};

	assign rf.rs1_addr = if_instr_i[19:15];
	assign rf.rs2_addr = if_instr_i[24:20];

	assign op_f7_ok = (funct7 == 7'b0000000) ||
		((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));

	always_comb
	begin
		dec          = '0; // nop unless recognised
		dec.alu_op   = ADD;
		dec.mem_len  = WORD;
		dec.rd       = if_instr_i[11:7];
		dec.rs1      = rf.rs1_addr;
		dec.rs2      = rf.rs2_addr;
		dec.rs1_data = rf.rs1_data;
		dec.rs2_data = rf.rs2_data;

		case (opcode)
			LUI:
			begin
				dec.alu_op  = PASS_B;
				dec.use_imm = 1'b1;
				dec.imm     = imm_u;
				dec.rf_we   = 1'b1;
			end
			OP_IMM:
			begin
				dec.use_imm = 1'b1;
				dec.imm     = imm_i;
				dec.rf_we   = 1'b1;
				case (funct3)
					3'b000: dec.alu_op = ADD;
					3'b010: dec.alu_op = SLT;
					3'b011: dec.alu_op = SLTU;
					3'b100: dec.alu_op = XOR;
					3'b110: dec.alu_op = OR;
					3'b111: dec.alu_op = AND;
					3'b001:
					begin
						dec.alu_op = SLL;
						dec.rf_we  = (funct7 == 7'b0000000);
					end
					default: // 101, srli / srai
					begin
						dec.alu_op = funct7[5] ? SRA : SRL;
						dec.rf_we  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					end
				endcase
			end
			OP:
			begin
				dec.rf_we = op_f7_ok;
				case (funct3)
					3'b000: dec.alu_op = funct7[5] ? SUB : ADD;
					3'b001: dec.alu_op = SLL;
					3'b010: dec.alu_op = SLT;
					3'b011: dec.alu_op = SLTU;
					3'b100: dec.alu_op = XOR;
					3'b101: dec.alu_op = funct7[5] ? SRA : SRL;
					3'b110: dec.alu_op = OR;
					default: dec.alu_op = AND;
				endcase
			end
			STORE:
			begin
				dec.use_imm = 1'b1; // address = rs1 + imm
				dec.imm     = imm_s;
				dec.store   = (funct3 <= 3'b010);
				dec.mem_len = mem_len_t'(funct3[1:0]);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			id_ex_o <= '0;
		else
			id_ex_o <= dec;
	end

	a_we_xor_store: assert property (@(posedge clk_i) disable iff (!reset_i)
		!(id_ex_o.rf_we && id_ex_o.store));

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; #(
	parameter word_t RESET_VECTOR = 32'h0
) (
	input  logic  clk_i,
	input  logic  reset_i,
	input  word_t instr_i,
	output word_t instr_addr_o,
	output word_t if_pc_o,
	output word_t if_instr_o
);

	word_t pc_q;    // address of the word now on instr_i
	word_t pc_next;

	// reset vector is held on the bus while in reset
	assign pc_next      = reset_i ? pc_q + 32'd4 : RESET_VECTOR;
	assign instr_addr_o = pc_next;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			pc_q       <= RESET_VECTOR;
			if_pc_o    <= RESET_VECTOR;
			if_instr_o <= NOP_INSTR;
		end
		else
		begin
			pc_q       <= pc_next;
			if_pc_o    <= pc_q;    // tag the returned word
			if_instr_o <= instr_i;
		end
	end

endmodule

/* hdl/regfile_if.sv */
`timescale 1ns/1ps

interface regfile_if import core_pkg::*; ();

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t     rs1_data;
	word_t     rs2_data;

	// writeback port, sampled on falling edge
	logic      wb_we;
	reg_addr_t wb_addr;
	word_t     wb_data;

	modport reader (output rs1_addr, rs2_addr, input rs1_data, rs2_data);

	modport writer (output wb_we, wb_addr, wb_data);

	modport bank (
		input  rs1_addr, rs2_addr, wb_we, wb_addr, wb_data,
		output rs1_data, rs2_data
	);

endinterface

/* hdl/core_pkg.sv */
package core_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		STORE  = 7'b0100011
	} opcode_t;

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		PASS_B // lui
	} alu_op_t;

	typedef enum logic [1:0] {
		BYTE = 2'd0, // same as store funct3[1:0]
		HALF = 2'd1,
		WORD = 2'd2
	} mem_len_t;

	localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

	typedef struct packed {
		alu_op_t   alu_op;
		logic      use_imm; // operand b from imm
		logic      rf_we;
		logic      store;
		mem_len_t  mem_len;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t     imm;
		word_t     rs1_data;
		word_t     rs2_data;
	} id_ex_t;

endpackage
